// ==== Bender.yml ====
package:
  name: io_tile_node

sources:
  - common/io_noc_pkg.sv
  - source/io_cmd_packetizer.sv
  - source/noc_link_fifo.sv
  - router/wormhole_input_ctrl.sv
  - router/wormhole_router_1d.sv
  - source/io_cmd_depacketizer.sv
  - source/io_tile_node.sv
  - target: simulation
    files:
      - sim/tb_io_tile_node.sv

// ==== common/io_noc_pkg.sv ====
package io_noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // flit and field widths
  localparam int flit_width_lp = 16;
  localparam int cord_width_lp = 3;
  localparam int len_width_lp  = 2;
  localparam int op_width_lp   = 3;
  localparam int max_body_lp   = 3;
  localparam int data_width_lp = max_body_lp * flit_width_lp; // one command payload.

  // ~~~~~~~~~~~~~~~~~~~~
  // header flit layout, upper bits are zero
  localparam int dest_lsb_lp = 0;
  localparam int len_lsb_lp  = dest_lsb_lp + cord_width_lp;
  localparam int src_lsb_lp  = len_lsb_lp + len_width_lp;
  localparam int op_lsb_lp   = src_lsb_lp + cord_width_lp;

  typedef enum logic [op_width_lp-1:0]
  {
    e_io_read,
    e_io_write,
    e_io_fence,
    e_io_ack
  } io_op_e;

  typedef enum logic [1:0]
  {
    e_port_p,
    e_port_w,
    e_port_e
  } port_e;

  typedef enum logic [1:0]
  {
    e_pktz_idle,
    e_pktz_head,
    e_pktz_body
  } pktz_state_e;

  typedef enum logic
  {
    e_rt_head,
    e_rt_body
  } route_state_e;

endpackage

// ==== router/wormhole_input_ctrl.sv ====
module wormhole_input_ctrl
  (input                                    clk_i
   , input                                  rst_n_i
   , input [io_noc_pkg::cord_width_lp-1:0]  my_cord_i

   , input                                  in_v_i
   , input [io_noc_pkg::flit_width_lp-1:0]  in_data_i
   , input                                  sent_i

   , output logic [2:0]                     req_o
   , output logic                           last_o
   );

  io_noc_pkg::route_state_e state_r;
  logic [2:0] route_r;
  logic [2:0] route_dec;
  logic [io_noc_pkg::len_width_lp-1:0] rem_r;
  logic [io_noc_pkg::len_width_lp-1:0] hdr_len;
  logic [io_noc_pkg::cord_width_lp-1:0] dest;

  assign dest    = in_data_i[io_noc_pkg::dest_lsb_lp +: io_noc_pkg::cord_width_lp];
  assign hdr_len = in_data_i[io_noc_pkg::len_lsb_lp +: io_noc_pkg::len_width_lp];

  // strict X: smaller coordinates lie to the west.
  always_comb
  begin
    route_dec = '0;
    if (dest < my_cord_i)
      route_dec[io_noc_pkg::e_port_w] = 1'b1;
    else if (dest > my_cord_i)
      route_dec[io_noc_pkg::e_port_e] = 1'b1;
    else
      route_dec[io_noc_pkg::e_port_p] = 1'b1;
  end

  assign req_o  = !in_v_i ? '0 : (state_r == io_noc_pkg::e_rt_head) ? route_dec : route_r;
  assign last_o = (state_r == io_noc_pkg::e_rt_head) ? (hdr_len == '0) : (rem_r == 1'b1);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state_r <= io_noc_pkg::e_rt_head;
    else if (sent_i)
    begin
      if (state_r == io_noc_pkg::e_rt_head && hdr_len != '0)
        state_r <= io_noc_pkg::e_rt_body;
      else if (state_r == io_noc_pkg::e_rt_body && rem_r == 1'b1)
        state_r <= io_noc_pkg::e_rt_head;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (sent_i && state_r == io_noc_pkg::e_rt_head)
    begin
      route_r <= route_dec; // body flits follow the header's route.
      rem_r   <= hdr_len;
    end
    else if (sent_i)
      rem_r <= rem_r - 1'b1;
  end

endmodule

// ==== router/wormhole_router_1d.sv ====
module wormhole_router_1d
  (input                                           clk_i
   , input                                         rst_n_i
   , input [io_noc_pkg::cord_width_lp-1:0]         my_cord_i

   , input                                         p_in_v_i
   , input [io_noc_pkg::flit_width_lp-1:0]         p_in_data_i
   , output logic                                  p_in_ready_and_o
   , output logic                                  p_out_v_o
   , output logic [io_noc_pkg::flit_width_lp-1:0]  p_out_data_o
   , input                                         p_out_ready_and_i

   , input                                         w_in_v_i
   , input [io_noc_pkg::flit_width_lp-1:0]         w_in_data_i
   , output logic                                  w_in_ready_and_o
   , output logic                                  w_out_v_o
   , output logic [io_noc_pkg::flit_width_lp-1:0]  w_out_data_o
   , input                                         w_out_ready_and_i

   , input                                         e_in_v_i
   , input [io_noc_pkg::flit_width_lp-1:0]         e_in_data_i
   , output logic                                  e_in_ready_and_o
   , output logic                                  e_out_v_o
   , output logic [io_noc_pkg::flit_width_lp-1:0]  e_out_data_o
   , input                                         e_out_ready_and_i
   );

  logic [2:0] in_v;
  logic [2:0] in_ready;
  logic [2:0] sent;
  logic [2:0] last;
  logic [2:0] out_v;
  logic [2:0] out_ready;
  logic [2:0] locked_r;
  logic [2:0][io_noc_pkg::flit_width_lp-1:0] in_data;
  logic [2:0][io_noc_pkg::flit_width_lp-1:0] out_data;
  logic [2:0][2:0] req;     // indexed by input, one bit per output.
  logic [2:0][2:0] req_out; // indexed by output, one bit per input.
  logic [2:0][2:0] gnt;
  logic [2:0][2:0] owner_r; // last winner, also the lock holder.

  function automatic logic [2:0] rr_pick(input logic [2:0] reqs, input logic [2:0] prev);
    logic [2:0] pick;
    int base;
    pick = '0;
    base = prev[0] ? 0 : (prev[1] ? 1 : 2);
    for (int k = 1; k <= 3; k++)
    begin
      if (pick == '0 && reqs[(base + k) % 3])
        pick[(base + k) % 3] = 1'b1;
    end
    return pick;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // port bundling
  assign in_v[io_noc_pkg::e_port_p]      = p_in_v_i;
  assign in_v[io_noc_pkg::e_port_w]      = w_in_v_i;
  assign in_v[io_noc_pkg::e_port_e]      = e_in_v_i;
  assign in_data[io_noc_pkg::e_port_p]   = p_in_data_i;
  assign in_data[io_noc_pkg::e_port_w]   = w_in_data_i;
  assign in_data[io_noc_pkg::e_port_e]   = e_in_data_i;
  assign out_ready[io_noc_pkg::e_port_p] = p_out_ready_and_i;
  assign out_ready[io_noc_pkg::e_port_w] = w_out_ready_and_i;
  assign out_ready[io_noc_pkg::e_port_e] = e_out_ready_and_i;

  assign p_in_ready_and_o = in_ready[io_noc_pkg::e_port_p];
  assign w_in_ready_and_o = in_ready[io_noc_pkg::e_port_w];
  assign e_in_ready_and_o = in_ready[io_noc_pkg::e_port_e];
  assign p_out_v_o        = out_v[io_noc_pkg::e_port_p];
  assign w_out_v_o        = out_v[io_noc_pkg::e_port_w];
  assign e_out_v_o        = out_v[io_noc_pkg::e_port_e];
  assign p_out_data_o     = out_data[io_noc_pkg::e_port_p];
  assign w_out_data_o     = out_data[io_noc_pkg::e_port_w];
  assign e_out_data_o     = out_data[io_noc_pkg::e_port_e];

  for (genvar i = 0; i < 3; i++)
  begin : in_ctrl
    wormhole_input_ctrl ctrl
      (.clk_i(clk_i)
       ,.rst_n_i(rst_n_i)
       ,.my_cord_i(my_cord_i)
       ,.in_v_i(in_v[i])
       ,.in_data_i(in_data[i])
       ,.sent_i(sent[i])
       ,.req_o(req[i])
       ,.last_o(last[i])
       );
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // output arbitration
  always_comb
  begin
    for (int o = 0; o < 3; o++)
    begin
      for (int i = 0; i < 3; i++)
        req_out[o][i] = req[i][o];
      gnt[o]      = locked_r[o] ? owner_r[o] : rr_pick(req_out[o], owner_r[o]);
      out_v[o]    = |(gnt[o] & req_out[o]);
      out_data[o] = '0;
      for (int i = 0; i < 3; i++)
        if (gnt[o][i])
          out_data[o] = in_data[i];
    end
    for (int i = 0; i < 3; i++)
    begin
      in_ready[i] = 1'b0;
      for (int o = 0; o < 3; o++)
        in_ready[i] = in_ready[i] | (gnt[o][i] & out_ready[o]);
      sent[i] = in_v[i] & in_ready[i];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      locked_r <= '0;
      owner_r  <= {3{3'b100}}; // the local port wins the first tie.
    end
    else
      for (int o = 0; o < 3; o++)
        if (out_v[o])
        begin
          locked_r[o] <= ~(out_ready[o] & |(gnt[o] & last)); // released by the tail flit.
          owner_r[o]  <= gnt[o]; // a stalled header keeps its grant.
        end
  end

endmodule

// ==== sim/tb_io_tile_node.sv ====
module tb_io_tile_node;

  typedef logic [io_noc_pkg::flit_width_lp-1:0] flit_t;
  typedef logic [io_noc_pkg::cord_width_lp-1:0] cord_t;
  typedef logic [io_noc_pkg::len_width_lp-1:0]  len_t;
  typedef logic [io_noc_pkg::data_width_lp-1:0] data_t;
  typedef logic [io_noc_pkg::op_width_lp+io_noc_pkg::cord_width_lp
                 +io_noc_pkg::len_width_lp+io_noc_pkg::data_width_lp-1:0] resp_t;

  localparam int num_pkts_lp       = 20;
  localparam int timeout_cycles_lp = num_pkts_lp * 40 + 200;
  localparam cord_t my_cord_lp     = 3'd3;
  localparam cord_t west_cord_lp   = 3'd2;
  localparam cord_t east_cord_lp   = 3'd4;

  logic clk = 1'b0;
  logic rst_n;
  logic cmd_v;
  logic cmd_ready;
  io_noc_pkg::io_op_e cmd_op;
  cord_t cmd_dest;
  len_t cmd_len;
  data_t cmd_data;
  logic resp_v;
  io_noc_pkg::io_op_e resp_op;
  cord_t resp_src;
  len_t resp_len;
  data_t resp_data;
  logic w_in_v;
  flit_t w_in_data;
  logic w_in_ready;
  logic w_out_v;
  flit_t w_out_data;
  logic w_out_ready = 1'b1;
  logic e_in_v;
  flit_t e_in_data;
  logic e_in_ready;
  logic e_out_v;
  flit_t e_out_data;
  logic e_out_ready = 1'b1;

  flit_t exp_w[$];
  flit_t exp_e_loc[$];  // east flits sent by the local endpoint.
  flit_t exp_e_pass[$]; // east flits that came in from the west.
  resp_t exp_resp[$];
  int value_errs = 0;
  int link_errs = 0;
  int other_errs = 0;
  int e_rem = 0;
  bit e_from_loc = 1'b0;
  bit bp_en = 1'b0;
  integer seed = 32'h214e_3ed6;
  string test_name = "reset";
  io_noc_pkg::io_op_e bp_op[6];
  cord_t bp_dest[6];
  len_t bp_len[6];
  data_t bp_data[6];

  io_tile_node dut0
    (.clk_i(clk), .rst_n_i(rst_n), .my_cord_i(my_cord_lp)
     ,.cmd_v_i(cmd_v), .cmd_ready_o(cmd_ready), .cmd_op_i(cmd_op)
     ,.cmd_dest_i(cmd_dest), .cmd_len_i(cmd_len), .cmd_data_i(cmd_data)
     ,.resp_v_o(resp_v), .resp_op_o(resp_op), .resp_src_o(resp_src)
     ,.resp_len_o(resp_len), .resp_data_o(resp_data)
     ,.link_w_v_i(w_in_v), .link_w_data_i(w_in_data), .link_w_ready_and_o(w_in_ready)
     ,.link_w_v_o(w_out_v), .link_w_data_o(w_out_data), .link_w_ready_and_i(w_out_ready)
     ,.link_e_v_i(e_in_v), .link_e_data_i(e_in_data), .link_e_ready_and_o(e_in_ready)
     ,.link_e_v_o(e_out_v), .link_e_data_o(e_out_data), .link_e_ready_and_i(e_out_ready)
     );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    if (bp_en)
    begin
      e_out_ready <= (($random(seed) & 32'h3) != 0); // neighbours stall a quarter of cycles.
      w_out_ready <= (($random(seed) & 32'h3) != 0);
    end
    else
    begin
      e_out_ready <= 1'b1;
      w_out_ready <= 1'b1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // scoreboard
  function automatic flit_t make_header(input io_noc_pkg::io_op_e op, input cord_t dest,
                                        input len_t len, input cord_t src);
    return {5'b0, op, src, len, dest};
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    assert (exp_v === act_v)
    else
    begin
      value_errs++;
      $display("Error %s %s: expected %h, actual %h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic expect_packet(input io_noc_pkg::io_op_e op, input cord_t dest,
                               input len_t len, input cord_t src, input data_t data);
    flit_t f;
    data_t used;
    used = '0;
    for (int k = 0; k <= len; k++)
    begin
      f = (k == 0) ? make_header(op, dest, len, src) : data[(k-1)*16 +: 16];
      if (k != 0)
        used[(k-1)*16 +: 16] = f;
      if (dest < my_cord_lp)
        exp_w.push_back(f);
      else if (dest > my_cord_lp && src == my_cord_lp)
        exp_e_loc.push_back(f);
      else if (dest > my_cord_lp)
        exp_e_pass.push_back(f);
    end
    if (dest == my_cord_lp)
      exp_resp.push_back({op, src, len, used});
  endtask

  task automatic take_east_flit(input flit_t f);
    if (e_rem == 0)
    begin
      e_from_loc = (f[io_noc_pkg::src_lsb_lp +: io_noc_pkg::cord_width_lp] == my_cord_lp);
      e_rem = f[io_noc_pkg::len_lsb_lp +: io_noc_pkg::len_width_lp];
    end
    else
      e_rem--;
    assert ((e_from_loc ? exp_e_loc.size() : exp_e_pass.size()) != 0)
    else
    begin
      other_errs++;
      $display("an unexpected flit %h left on the east link", f);
    end
    if (e_from_loc && exp_e_loc.size() != 0)
      check_value("east flit", exp_e_loc.pop_front(), f);
    else if (!e_from_loc && exp_e_pass.size() != 0)
      check_value("east flit", exp_e_pass.pop_front(), f);
  endtask

  task automatic take_west_flit(input flit_t f);
    assert (exp_w.size() != 0)
    else
    begin
      other_errs++;
      $display("an unexpected flit %h left on the west link", f);
    end
    if (exp_w.size() != 0)
      check_value("west flit", exp_w.pop_front(), f);
  endtask

  task automatic take_response;
    resp_t act;
    act = {resp_op, resp_src, resp_len, resp_data};
    assert (exp_resp.size() != 0)
    else
    begin
      other_errs++;
      $display("a response pulse came out that no packet asked for");
    end
    if (exp_resp.size() != 0)
      check_value("response", exp_resp.pop_front(), act);
  endtask

  always @(negedge clk)
  begin
    if (rst_n && e_out_v && e_out_ready)
      take_east_flit(e_out_data);
    if (rst_n && w_out_v && w_out_ready)
      take_west_flit(w_out_data);
    if (rst_n && resp_v)
      take_response();
  end

  // a stalled flit must stay on the link unchanged.
  assert property (@(posedge clk) disable iff (!rst_n)
                   (e_out_v && !e_out_ready) |=> (e_out_v && $stable(e_out_data)))
  else
  begin
    link_errs++;
    $display("the east output dropped or changed a flit before it was taken");
  end

  assert property (@(posedge clk) disable iff (!rst_n)
                   (w_out_v && !w_out_ready) |=> (w_out_v && $stable(w_out_data)))
  else
  begin
    link_errs++;
    $display("the west output dropped or changed a flit before it was taken");
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  task automatic send_cmd(input io_noc_pkg::io_op_e op, input cord_t dest,
                          input len_t len, input data_t data);
    expect_packet(op, dest, len, my_cord_lp, data);
    @(posedge clk);
    cmd_v    <= 1'b1;
    cmd_op   <= op;
    cmd_dest <= dest;
    cmd_len  <= len;
    cmd_data <= data;
    @(negedge clk);
    while (!cmd_ready)
      @(negedge clk);
    @(posedge clk);
    cmd_v <= 1'b0;
  endtask

  task automatic send_link(input bit east_side, input io_noc_pkg::io_op_e op,
                           input cord_t dest, input len_t len, input cord_t src,
                           input data_t data);
    flit_t f;
    expect_packet(op, dest, len, src, data);
    for (int k = 0; k <= len; k++)
    begin
      f = (k == 0) ? make_header(op, dest, len, src) : data[(k-1)*16 +: 16];
      @(posedge clk);
      if (east_side)
      begin
        e_in_v    <= 1'b1;
        e_in_data <= f;
      end
      else
      begin
        w_in_v    <= 1'b1;
        w_in_data <= f;
      end
      @(negedge clk);
      while (!(east_side ? e_in_ready : w_in_ready))
        @(negedge clk);
    end
    @(posedge clk);
    if (east_side)
      e_in_v <= 1'b0;
    else
      w_in_v <= 1'b0;
  endtask

  task automatic wait_drain;
    do
      @(negedge clk);
    while (exp_w.size() + exp_e_loc.size() + exp_e_pass.size() + exp_resp.size() != 0);
  endtask

  initial
  begin
    rst_n     <= 1'b0;
    cmd_v     <= 1'b0;
    cmd_op    <= io_noc_pkg::e_io_read;
    cmd_dest  <= '0;
    cmd_len   <= '0;
    cmd_data  <= '0;
    w_in_v    <= 1'b0;
    w_in_data <= '0;
    e_in_v    <= 1'b0;
    e_in_data <= '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("w_v e_v resp_v cmd_ready", 4'b0001, {w_out_v, e_out_v, resp_v, cmd_ready});

    test_name = "loopback";
    for (int l = 0; l < 4; l++)
      send_cmd(io_noc_pkg::io_op_e'(l), my_cord_lp, l, 48'hc3c3_a5a5_0f0f + l);
    wait_drain();

    test_name = "routing";
    send_cmd(io_noc_pkg::e_io_write, 3'd5, 2'd0, 48'h1111_2222_3333);
    send_cmd(io_noc_pkg::e_io_read, 3'd5, 2'd3, 48'h4444_5555_6666);
    send_cmd(io_noc_pkg::e_io_fence, 3'd1, 2'd1, 48'h7777_8888_9999);
    send_cmd(io_noc_pkg::e_io_ack, 3'd1, 2'd2, 48'haaaa_bbbb_cccc);
    wait_drain();

    test_name = "pass_through";
    send_link(1'b0, io_noc_pkg::e_io_write, 3'd6, 2'd2, west_cord_lp, 48'h0d0d_0e0e_0f0f);
    send_link(1'b1, io_noc_pkg::e_io_read, 3'd3, 2'd3, east_cord_lp, 48'h1a1a_2b2b_3c3c);
    wait_drain();

    test_name = "back_pressure";
    for (int n = 0; n < 6; n++)
    begin
      bp_op[n]   = io_noc_pkg::io_op_e'($random(seed) & 32'h3);
      bp_dest[n] = n[0] ? cord_t'($random(seed) & 32'h1)             // west of this tile.
                        : 3'd4 + cord_t'($random(seed) & 32'h3);     // east of this tile.
      bp_len[n]  = len_t'($random(seed));
      bp_data[n] = {$random(seed), $random(seed)};
    end
    bp_en = 1'b1;
    for (int n = 0; n < 6; n++)
      send_cmd(bp_op[n], bp_dest[n], bp_len[n], bp_data[n]);
    wait_drain();

    test_name = "contention";
    for (int r = 0; r < 2; r++)
    begin
      fork
        send_cmd(io_noc_pkg::e_io_write, 3'd5, 2'd3, 48'h5150_5151_5152 + r);
        send_link(1'b0, io_noc_pkg::e_io_read, 3'd7, 2'd3, west_cord_lp,
                  48'h7170_7171_7172 + r);
      join
      wait_drain();
    end
    bp_en = 1'b0;

    $display("errors: value %0d, link %0d, other %0d", value_errs, link_errs, other_errs);
    if (value_errs + link_errs + other_errs == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

  initial
  begin
    repeat (timeout_cycles_lp) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles_lp);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== source/io_cmd_depacketizer.sv ====
module io_cmd_depacketizer
  (input                                           clk_i
   , input                                         rst_n_i

   , input                                         link_v_i
   , input [io_noc_pkg::flit_width_lp-1:0]         link_data_i
   , output logic                                  link_ready_and_o

   , output logic                                  resp_v_o
   , output io_noc_pkg::io_op_e                    resp_op_o
   , output logic [io_noc_pkg::cord_width_lp-1:0]  resp_src_o
   , output logic [io_noc_pkg::len_width_lp-1:0]   resp_len_o
   , output logic [io_noc_pkg::data_width_lp-1:0]  resp_data_o
   );

  io_noc_pkg::route_state_e state_r;
  logic [io_noc_pkg::len_width_lp-1:0] cnt_r;
  logic [io_noc_pkg::len_width_lp-1:0] hdr_len;
  logic last_flit;

  assign link_ready_and_o = 1'b1; // responses are never refused.
  assign hdr_len = link_data_i[io_noc_pkg::len_lsb_lp +: io_noc_pkg::len_width_lp];
  assign last_flit = (state_r == io_noc_pkg::e_rt_head) ? (hdr_len == '0)
                                                        : (cnt_r == resp_len_o - 1'b1);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_r  <= io_noc_pkg::e_rt_head;
      resp_v_o <= 1'b0;
    end
    else
    begin
      resp_v_o <= link_v_i & last_flit;
      if (link_v_i && state_r == io_noc_pkg::e_rt_head && hdr_len != '0)
        state_r <= io_noc_pkg::e_rt_body;
      else if (link_v_i && state_r == io_noc_pkg::e_rt_body && last_flit)
        state_r <= io_noc_pkg::e_rt_head;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (link_v_i && state_r == io_noc_pkg::e_rt_head)
    begin
      resp_op_o   <= io_noc_pkg::io_op_e'(
                       link_data_i[io_noc_pkg::op_lsb_lp +: io_noc_pkg::op_width_lp]);
      resp_src_o  <= link_data_i[io_noc_pkg::src_lsb_lp +: io_noc_pkg::cord_width_lp];
      resp_len_o  <= hdr_len;
      resp_data_o <= '0; // words past len stay zero.
      cnt_r       <= '0;
    end
    else if (link_v_i)
    begin
      resp_data_o[cnt_r*io_noc_pkg::flit_width_lp +: io_noc_pkg::flit_width_lp] <= link_data_i;
      cnt_r <= cnt_r + 1'b1;
    end
  end

endmodule

// ==== source/io_cmd_packetizer.sv ====
module io_cmd_packetizer
  (input                                           clk_i
   , input                                         rst_n_i
   , input [io_noc_pkg::cord_width_lp-1:0]         my_cord_i

   , input                                         cmd_v_i
   , output logic                                  cmd_ready_o
   , input io_noc_pkg::io_op_e                     cmd_op_i
   , input [io_noc_pkg::cord_width_lp-1:0]         cmd_dest_i
   , input [io_noc_pkg::len_width_lp-1:0]          cmd_len_i
   , input [io_noc_pkg::data_width_lp-1:0]         cmd_data_i

   , output logic                                  link_v_o
   , output logic [io_noc_pkg::flit_width_lp-1:0]  link_data_o
   , input                                         link_ready_and_i
   );

  io_noc_pkg::pktz_state_e state_r;
  logic [io_noc_pkg::data_width_lp+io_noc_pkg::flit_width_lp-1:0] pkt_r;
  logic [io_noc_pkg::len_width_lp-1:0] rem_r;
  logic [io_noc_pkg::flit_width_lp-1:0] header;
  logic accept;
  logic xfer;

  assign cmd_ready_o = (state_r == io_noc_pkg::e_pktz_idle);
  assign accept      = cmd_v_i & cmd_ready_o;
  assign link_v_o    = (state_r != io_noc_pkg::e_pktz_idle);
  assign link_data_o = pkt_r[io_noc_pkg::flit_width_lp-1:0]; // the flit on offer sits at the bottom.
  assign xfer        = link_v_o & link_ready_and_i;

  always_comb
  begin
    header = '0;
    header[io_noc_pkg::dest_lsb_lp +: io_noc_pkg::cord_width_lp] = cmd_dest_i;
    header[io_noc_pkg::len_lsb_lp +: io_noc_pkg::len_width_lp]   = cmd_len_i;
    header[io_noc_pkg::src_lsb_lp +: io_noc_pkg::cord_width_lp]  = my_cord_i;
    header[io_noc_pkg::op_lsb_lp +: io_noc_pkg::op_width_lp]     = cmd_op_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      state_r <= io_noc_pkg::e_pktz_idle;
    else
      case (state_r)
        io_noc_pkg::e_pktz_idle:
          if (accept)
            state_r <= io_noc_pkg::e_pktz_head;
        io_noc_pkg::e_pktz_head:
          if (xfer)
          begin
            if (rem_r == '0)
              state_r <= io_noc_pkg::e_pktz_idle;
            else
              state_r <= io_noc_pkg::e_pktz_body;
          end
        io_noc_pkg::e_pktz_body:
          if (xfer && rem_r == 1'b1)
            state_r <= io_noc_pkg::e_pktz_idle;
        default:
          state_r <= io_noc_pkg::e_pktz_idle;
      endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      pkt_r <= {cmd_data_i, header};
      rem_r <= cmd_len_i;
    end
    else if (xfer)
    begin
      pkt_r <= pkt_r >> io_noc_pkg::flit_width_lp; // next body word moves down.
      if (state_r == io_noc_pkg::e_pktz_body)
        rem_r <= rem_r - 1'b1;
    end
  end

endmodule

// ==== source/io_tile_node.sv ====
module io_tile_node
  (input                                           clk_i
   , input                                         rst_n_i
   , input [io_noc_pkg::cord_width_lp-1:0]         my_cord_i

   , input                                         cmd_v_i
   , output logic                                  cmd_ready_o
   , input io_noc_pkg::io_op_e                     cmd_op_i
   , input [io_noc_pkg::cord_width_lp-1:0]         cmd_dest_i
   , input [io_noc_pkg::len_width_lp-1:0]          cmd_len_i
   , input [io_noc_pkg::data_width_lp-1:0]         cmd_data_i

   , output logic                                  resp_v_o
   , output io_noc_pkg::io_op_e                    resp_op_o
   , output logic [io_noc_pkg::cord_width_lp-1:0]  resp_src_o
   , output logic [io_noc_pkg::len_width_lp-1:0]   resp_len_o
   , output logic [io_noc_pkg::data_width_lp-1:0]  resp_data_o

   , input                                         link_w_v_i
   , input [io_noc_pkg::flit_width_lp-1:0]         link_w_data_i
   , output logic                                  link_w_ready_and_o
   , output logic                                  link_w_v_o
   , output logic [io_noc_pkg::flit_width_lp-1:0]  link_w_data_o
   , input                                         link_w_ready_and_i

   , input                                         link_e_v_i
   , input [io_noc_pkg::flit_width_lp-1:0]         link_e_data_i
   , output logic                                  link_e_ready_and_o
   , output logic                                  link_e_v_o
   , output logic [io_noc_pkg::flit_width_lp-1:0]  link_e_data_o
   , input                                         link_e_ready_and_i
   );

  // packetizer to inject FIFO
  logic                                  pktz_v;
  logic [io_noc_pkg::flit_width_lp-1:0]  pktz_data;
  logic                                  pktz_ready_and;

  // inject FIFO to router local input
  logic                                  inj_v;
  logic [io_noc_pkg::flit_width_lp-1:0]  inj_data;
  logic                                  inj_ready_and;

  // router local output to eject FIFO
  logic                                  ej_v;
  logic [io_noc_pkg::flit_width_lp-1:0]  ej_data;
  logic                                  ej_ready_and;

  // eject FIFO to depacketizer
  logic                                  dpkt_v;
  logic [io_noc_pkg::flit_width_lp-1:0]  dpkt_data;
  logic                                  dpkt_ready_and;

  io_cmd_packetizer packetizer
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.my_cord_i(my_cord_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.cmd_op_i(cmd_op_i)
     ,.cmd_dest_i(cmd_dest_i)
     ,.cmd_len_i(cmd_len_i)
     ,.cmd_data_i(cmd_data_i)
     ,.link_v_o(pktz_v)
     ,.link_data_o(pktz_data)
     ,.link_ready_and_i(pktz_ready_and)
     );

  noc_link_fifo #(.els_p(2)) inject_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.v_i(pktz_v)
     ,.data_i(pktz_data)
     ,.ready_and_o(pktz_ready_and)
     ,.v_o(inj_v)
     ,.data_o(inj_data)
     ,.ready_and_i(inj_ready_and)
     );

  wormhole_router_1d router
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.my_cord_i(my_cord_i)
     ,.p_in_v_i(inj_v)
     ,.p_in_data_i(inj_data)
     ,.p_in_ready_and_o(inj_ready_and)
     ,.p_out_v_o(ej_v)
     ,.p_out_data_o(ej_data)
     ,.p_out_ready_and_i(ej_ready_and)
     ,.w_in_v_i(link_w_v_i)
     ,.w_in_data_i(link_w_data_i)
     ,.w_in_ready_and_o(link_w_ready_and_o)
     ,.w_out_v_o(link_w_v_o)
     ,.w_out_data_o(link_w_data_o)
     ,.w_out_ready_and_i(link_w_ready_and_i)
     ,.e_in_v_i(link_e_v_i)
     ,.e_in_data_i(link_e_data_i)
     ,.e_in_ready_and_o(link_e_ready_and_o)
     ,.e_out_v_o(link_e_v_o)
     ,.e_out_data_o(link_e_data_o)
     ,.e_out_ready_and_i(link_e_ready_and_i)
     );

  noc_link_fifo #(.els_p(2)) eject_fifo
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.v_i(ej_v)
     ,.data_i(ej_data)
     ,.ready_and_o(ej_ready_and)
     ,.v_o(dpkt_v)
     ,.data_o(dpkt_data)
     ,.ready_and_i(dpkt_ready_and)
     );

  io_cmd_depacketizer depacketizer
    (.clk_i(clk_i)
     ,.rst_n_i(rst_n_i)
     ,.link_v_i(dpkt_v)
     ,.link_data_i(dpkt_data)
     ,.link_ready_and_o(dpkt_ready_and)
     ,.resp_v_o(resp_v_o)
     ,.resp_op_o(resp_op_o)
     ,.resp_src_o(resp_src_o)
     ,.resp_len_o(resp_len_o)
     ,.resp_data_o(resp_data_o)
     );

endmodule

// ==== source/noc_link_fifo.sv ====
module noc_link_fifo
  #(parameter int els_p = 2)
  (input                                           clk_i
   , input                                         rst_n_i

   , input                                         v_i
   , input [io_noc_pkg::flit_width_lp-1:0]         data_i
   , output logic                                  ready_and_o

   , output logic                                  v_o
   , output logic [io_noc_pkg::flit_width_lp-1:0]  data_o
   , input                                         ready_and_i
   );

  logic [io_noc_pkg::flit_width_lp-1:0] mem_r [els_p];
  logic [$clog2(els_p)-1:0] wr_ptr_r;
  logic [$clog2(els_p)-1:0] rd_ptr_r;
  logic [$clog2(els_p+1)-1:0] count_r;
  logic push;
  logic pop;

  assign ready_and_o = (count_r != els_p);
  assign v_o         = (count_r != '0);
  assign data_o      = mem_r[rd_ptr_r];
  assign push        = v_i & ready_and_o;
  assign pop         = v_o & ready_and_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= (wr_ptr_r == els_p - 1) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == els_p - 1) ? '0 : rd_ptr_r + 1'b1;
      if (push && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !push)
        count_r <= count_r - 1'b1; // a push and pop together leave the count alone.
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem_r[wr_ptr_r] <= data_i;
  end

endmodule

// ==== verilog.f ====
common/io_noc_pkg.sv
source/io_cmd_packetizer.sv
source/noc_link_fifo.sv
router/wormhole_input_ctrl.sv
router/wormhole_router_1d.sv
source/io_cmd_depacketizer.sv
source/io_tile_node.sv
sim/tb_io_tile_node.sv
